// ==== build.f ====
+incdir+hw
hw/huff_pkg.sv
hw/huff_req_if.sv
hw/huff_dc_rom.sv
hw/huff_ac_luma_rom.sv
hw/huff_lookup_lane.sv
hw/huff_tables.sv
testbench/tb_huff_tables.sv

// ==== hw/huff_ac_luma_rom.sv ====
`timescale 1ns/1ps
`include "huff_settings.svh"

module huff_ac_luma_rom
    import huff_pkg::*;
(
    input  logic [`HUFF_SYM_W-1:0] symbol,  // Run in high nibble, size in low nibble.
    output huff_entry_t            entry
);

    always_comb begin
        case (symbol)
            8'h01: entry = '{4'd1,  16'b00};
            8'h02: entry = '{4'd1,  16'b01};
            8'h03: entry = '{4'd2,  16'b100};
            8'h00: entry = '{4'd3,  16'b1010};  // End of block.
            8'h04: entry = '{4'd3,  16'b1011};
            8'h11: entry = '{4'd3,  16'b1100};
            8'h05: entry = '{4'd4,  16'b11010};
            8'h12: entry = '{4'd4,  16'b11011};
            8'h21: entry = '{4'd4,  16'b11100};
            8'h31: entry = '{4'd5,  16'b111010};
            8'h41: entry = '{4'd5,  16'b111011};
            8'h06: entry = '{4'd6,  16'b1111000};
            8'h13: entry = '{4'd6,  16'b1111001};
            8'h51: entry = '{4'd6,  16'b1111010};
            8'h61: entry = '{4'd6,  16'b1111011};
            8'h07: entry = '{4'd7,  16'b11111000};
            8'h22: entry = '{4'd7,  16'b11111001};
            8'h71: entry = '{4'd7,  16'b11111010};
            8'h14: entry = '{4'd8,  16'b111110110};
            8'h32: entry = '{4'd8,  16'b111110111};
            8'h81: entry = '{4'd8,  16'b111111000};
            8'h91: entry = '{4'd8,  16'b111111001};
            8'ha1: entry = '{4'd8,  16'b111111010};
            8'h08: entry = '{4'd9,  16'b1111110110};
            8'h23: entry = '{4'd9,  16'b1111110111};
            8'h42: entry = '{4'd9,  16'b1111111000};
            8'hb1: entry = '{4'd9,  16'b1111111001};
            8'hc1: entry = '{4'd9,  16'b1111111010};
            8'h15: entry = '{4'd10, 16'b11111110110};
            8'h52: entry = '{4'd10, 16'b11111110111};
            8'hd1: entry = '{4'd10, 16'b11111111000};
            8'hf0: entry = '{4'd10, 16'b11111111001};  // Run of sixteen zeros.
            8'h24: entry = '{4'd11, 16'b111111110100};
            8'h33: entry = '{4'd11, 16'b111111110101};
            8'h62: entry = '{4'd11, 16'b111111110110};
            8'h72: entry = '{4'd11, 16'b111111110111};
            8'h82: entry = '{4'd14, 16'b111111111000000};
            // All remaining codes are 16 bits, counting up from ff82.
            8'h09: entry = '{4'd15, 16'hff82};
            8'h0a: entry = '{4'd15, 16'hff83};
            8'h16: entry = '{4'd15, 16'hff84};
            8'h17: entry = '{4'd15, 16'hff85};
            8'h18: entry = '{4'd15, 16'hff86};
            8'h19: entry = '{4'd15, 16'hff87};
            8'h1a: entry = '{4'd15, 16'hff88};
            8'h25: entry = '{4'd15, 16'hff89};
            8'h26: entry = '{4'd15, 16'hff8a};
            8'h27: entry = '{4'd15, 16'hff8b};
            8'h28: entry = '{4'd15, 16'hff8c};
            8'h29: entry = '{4'd15, 16'hff8d};
            8'h2a: entry = '{4'd15, 16'hff8e};
            8'h34: entry = '{4'd15, 16'hff8f};
            8'h35: entry = '{4'd15, 16'hff90};
            8'h36: entry = '{4'd15, 16'hff91};
            8'h37: entry = '{4'd15, 16'hff92};
            8'h38: entry = '{4'd15, 16'hff93};
            8'h39: entry = '{4'd15, 16'hff94};
            8'h3a: entry = '{4'd15, 16'hff95};
            8'h43: entry = '{4'd15, 16'hff96};
            8'h44: entry = '{4'd15, 16'hff97};
            8'h45: entry = '{4'd15, 16'hff98};
            8'h46: entry = '{4'd15, 16'hff99};
            8'h47: entry = '{4'd15, 16'hff9a};
            8'h48: entry = '{4'd15, 16'hff9b};
            8'h49: entry = '{4'd15, 16'hff9c};
            8'h4a: entry = '{4'd15, 16'hff9d};
            8'h53: entry = '{4'd15, 16'hff9e};
            8'h54: entry = '{4'd15, 16'hff9f};
            8'h55: entry = '{4'd15, 16'hffa0};
            8'h56: entry = '{4'd15, 16'hffa1};
            8'h57: entry = '{4'd15, 16'hffa2};
            8'h58: entry = '{4'd15, 16'hffa3};
            8'h59: entry = '{4'd15, 16'hffa4};
            8'h5a: entry = '{4'd15, 16'hffa5};
            8'h63: entry = '{4'd15, 16'hffa6};
            8'h64: entry = '{4'd15, 16'hffa7};
            8'h65: entry = '{4'd15, 16'hffa8};
            8'h66: entry = '{4'd15, 16'hffa9};
            8'h67: entry = '{4'd15, 16'hffaa};
            8'h68: entry = '{4'd15, 16'hffab};
            8'h69: entry = '{4'd15, 16'hffac};
            8'h6a: entry = '{4'd15, 16'hffad};
            8'h73: entry = '{4'd15, 16'hffae};
            8'h74: entry = '{4'd15, 16'hffaf};
            8'h75: entry = '{4'd15, 16'hffb0};
            8'h76: entry = '{4'd15, 16'hffb1};
            8'h77: entry = '{4'd15, 16'hffb2};
            8'h78: entry = '{4'd15, 16'hffb3};
            8'h79: entry = '{4'd15, 16'hffb4};
            8'h7a: entry = '{4'd15, 16'hffb5};
            8'h83: entry = '{4'd15, 16'hffb6};
            8'h84: entry = '{4'd15, 16'hffb7};
            8'h85: entry = '{4'd15, 16'hffb8};
            8'h86: entry = '{4'd15, 16'hffb9};
            8'h87: entry = '{4'd15, 16'hffba};
            8'h88: entry = '{4'd15, 16'hffbb};
            8'h89: entry = '{4'd15, 16'hffbc};
            8'h8a: entry = '{4'd15, 16'hffbd};
            8'h92: entry = '{4'd15, 16'hffbe};
            8'h93: entry = '{4'd15, 16'hffbf};
            8'h94: entry = '{4'd15, 16'hffc0};
            8'h95: entry = '{4'd15, 16'hffc1};
            8'h96: entry = '{4'd15, 16'hffc2};
            8'h97: entry = '{4'd15, 16'hffc3};
            8'h98: entry = '{4'd15, 16'hffc4};
            8'h99: entry = '{4'd15, 16'hffc5};
            8'h9a: entry = '{4'd15, 16'hffc6};
            8'ha2: entry = '{4'd15, 16'hffc7};
            8'ha3: entry = '{4'd15, 16'hffc8};
            8'ha4: entry = '{4'd15, 16'hffc9};
            8'ha5: entry = '{4'd15, 16'hffca};
            8'ha6: entry = '{4'd15, 16'hffcb};
            8'ha7: entry = '{4'd15, 16'hffcc};
            8'ha8: entry = '{4'd15, 16'hffcd};
            8'ha9: entry = '{4'd15, 16'hffce};
            8'haa: entry = '{4'd15, 16'hffcf};
            8'hb2: entry = '{4'd15, 16'hffd0};
            8'hb3: entry = '{4'd15, 16'hffd1};
            8'hb4: entry = '{4'd15, 16'hffd2};
            8'hb5: entry = '{4'd15, 16'hffd3};
            8'hb6: entry = '{4'd15, 16'hffd4};
            8'hb7: entry = '{4'd15, 16'hffd5};
            8'hb8: entry = '{4'd15, 16'hffd6};
            8'hb9: entry = '{4'd15, 16'hffd7};
            8'hba: entry = '{4'd15, 16'hffd8};
            8'hc2: entry = '{4'd15, 16'hffd9};
            8'hc3: entry = '{4'd15, 16'hffda};
            8'hc4: entry = '{4'd15, 16'hffdb};
            8'hc5: entry = '{4'd15, 16'hffdc};
            8'hc6: entry = '{4'd15, 16'hffdd};
            8'hc7: entry = '{4'd15, 16'hffde};
            8'hc8: entry = '{4'd15, 16'hffdf};
            8'hc9: entry = '{4'd15, 16'hffe0};
            8'hca: entry = '{4'd15, 16'hffe1};
            8'hd2: entry = '{4'd15, 16'hffe2};
            8'hd3: entry = '{4'd15, 16'hffe3};
            8'hd4: entry = '{4'd15, 16'hffe4};
            8'hd5: entry = '{4'd15, 16'hffe5};
            8'hd6: entry = '{4'd15, 16'hffe6};
            8'hd7: entry = '{4'd15, 16'hffe7};
            8'hd8: entry = '{4'd15, 16'hffe8};
            8'hd9: entry = '{4'd15, 16'hffe9};
            8'hda: entry = '{4'd15, 16'hffea};
            8'he1: entry = '{4'd15, 16'hffeb};
            8'he2: entry = '{4'd15, 16'hffec};
            8'he3: entry = '{4'd15, 16'hffed};
            8'he4: entry = '{4'd15, 16'hffee};
            8'he5: entry = '{4'd15, 16'hffef};
            8'he6: entry = '{4'd15, 16'hfff0};
            8'he7: entry = '{4'd15, 16'hfff1};
            8'he8: entry = '{4'd15, 16'hfff2};
            8'he9: entry = '{4'd15, 16'hfff3};
            8'hea: entry = '{4'd15, 16'hfff4};
            8'hf1: entry = '{4'd15, 16'hfff5};
            8'hf2: entry = '{4'd15, 16'hfff6};
            8'hf3: entry = '{4'd15, 16'hfff7};
            8'hf4: entry = '{4'd15, 16'hfff8};
            8'hf5: entry = '{4'd15, 16'hfff9};
            8'hf6: entry = '{4'd15, 16'hfffa};
            8'hf7: entry = '{4'd15, 16'hfffb};
            8'hf8: entry = '{4'd15, 16'hfffc};
            8'hf9: entry = '{4'd15, 16'hfffd};
            8'hfa: entry = '{4'd15, 16'hfffe};
            default: entry = '0;  // Unlisted symbol.
        endcase
    end

endmodule

// ==== hw/huff_dc_rom.sv ====
`timescale 1ns/1ps
`include "huff_settings.svh"

module huff_dc_rom
    import huff_pkg::*;
(
    input  logic [`HUFF_SYM_W-1:0] symbol,
    input  logic                   chroma,
    output huff_entry_t            entry
);

    always_comb begin
        entry = '0;
        if (symbol < `HUFF_DC_SYMS) begin
            if (chroma) begin
                case (symbol[3:0])
                    4'h0:    entry = '{4'd1,  16'b00};
                    4'h1:    entry = '{4'd1,  16'b01};
                    4'h2:    entry = '{4'd1,  16'b10};
                    4'h3:    entry = '{4'd2,  16'b110};
                    4'h4:    entry = '{4'd3,  16'b1110};
                    4'h5:    entry = '{4'd4,  16'b11110};
                    4'h6:    entry = '{4'd5,  16'b111110};
                    4'h7:    entry = '{4'd6,  16'b1111110};
                    4'h8:    entry = '{4'd7,  16'b11111110};
                    4'h9:    entry = '{4'd8,  16'b111111110};
                    4'ha:    entry = '{4'd9,  16'b1111111110};
                    4'hb:    entry = '{4'd10, 16'b11111111110};
                    default: entry = '0;
                endcase
            end else begin
                case (symbol[3:0])
                    4'h0:    entry = '{4'd1,  16'b00};
                    4'h1:    entry = '{4'd2,  16'b010};
                    4'h2:    entry = '{4'd2,  16'b011};
                    4'h3:    entry = '{4'd2,  16'b100};
                    4'h4:    entry = '{4'd2,  16'b101};
                    4'h5:    entry = '{4'd2,  16'b110};
                    4'h6:    entry = '{4'd3,  16'b1110};
                    4'h7:    entry = '{4'd4,  16'b11110};
                    4'h8:    entry = '{4'd5,  16'b111110};
                    4'h9:    entry = '{4'd6,  16'b1111110};
                    4'ha:    entry = '{4'd7,  16'b11111110};
                    4'hb:    entry = '{4'd8,  16'b111111110};
                    default: entry = '0;
                endcase
            end
        end
    end

endmodule

// ==== hw/huff_lookup_lane.sv ====
`timescale 1ns/1ps
`include "huff_settings.svh"

module huff_lookup_lane
    import huff_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    huff_req_if.lane req
);

    huff_entry_t             dc_entry;
    huff_entry_t             ac_entry;
    huff_entry_t             sel_entry;
    logic [`HUFF_LEN_W-1:0]  len_next;

    huff_dc_rom i_dc_rom (
        .symbol (req.symbol),
        .chroma (req.sel == DC_CHROMA),
        .entry  (dc_entry)
    );

    huff_ac_luma_rom i_ac_luma_rom (
        .symbol (req.symbol),
        .entry  (ac_entry)
    );

    always_comb begin
        case (req.sel)
            DC_LUMA, DC_CHROMA: sel_entry = dc_entry;
            AC_LUMA:            sel_entry = ac_entry;
            default:            sel_entry = '0;  // AC chroma not held.
        endcase
    end

    // Restore the true length from the stored value.
    assign len_next = {{(`HUFF_LEN_W - `HUFF_LENM1_W){1'b0}}, sel_entry.lenm1} + 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req.len  <= '0;
            req.code <= '0;
        end else if (req.re) begin
            req.len  <= len_next;
            req.code <= sel_entry.code;
        end
    end

endmodule

// ==== hw/huff_pkg.sv ====
`include "huff_settings.svh"

package huff_pkg;

    typedef enum logic [1:0] {
        DC_LUMA   = 2'd0,
        DC_CHROMA = 2'd1,
        AC_LUMA   = 2'd2,
        AC_CHROMA = 2'd3  // Reserved, reads as zero.
    } huff_table_t;

    typedef struct packed {
        logic [`HUFF_LENM1_W-1:0] lenm1;  // Length minus one.
        logic [`HUFF_CODE_W-1:0]  code;
    } huff_entry_t;

endpackage

// ==== hw/huff_req_if.sv ====
`timescale 1ns/1ps
`include "huff_settings.svh"

interface huff_req_if
    import huff_pkg::*;
();
    logic [`HUFF_SYM_W-1:0]  symbol;
    logic                    re;      // Sampled each clock.
    huff_table_t             sel;
    logic [`HUFF_LEN_W-1:0]  len;
    logic [`HUFF_CODE_W-1:0] code;

    modport lane (
        input  symbol, re, sel,
        output len, code
    );

    modport host (
        output symbol, re, sel,
        input  len, code
    );
endinterface

// ==== hw/huff_settings.svh ====
`ifndef HUFF_SETTINGS_SVH
`define HUFF_SETTINGS_SVH

`define HUFF_SYM_W    8   // Input symbol width.
`define HUFF_CODE_W   16  // Right-aligned code word.
`define HUFF_LEN_W    5   // Code length 1..16.
`define HUFF_LENM1_W  4   // Stored length minus one.

`define HUFF_LANES    2   // Independent lookup lanes.

`define HUFF_DC_SYMS  12  // Categories 0..11.

`endif

// ==== hw/huff_tables.sv ====
`timescale 1ns/1ps
`include "huff_settings.svh"

module huff_tables
    import huff_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`HUFF_SYM_W-1:0]  symbol [`HUFF_LANES-1:0],
    input  logic                    re     [`HUFF_LANES-1:0],
    input  huff_table_t             sel    [`HUFF_LANES-1:0],
    output logic [`HUFF_LEN_W-1:0]  len    [`HUFF_LANES-1:0],
    output logic [`HUFF_CODE_W-1:0] code   [`HUFF_LANES-1:0]
);

    for (genvar i = 0; i < `HUFF_LANES; i++) begin : g_lane
        huff_req_if req ();

        assign req.symbol = symbol[i];
        assign req.re     = re[i];
        assign req.sel    = sel[i];
        assign len[i]     = req.len;   // Registered in the lane.
        assign code[i]    = req.code;

        huff_lookup_lane i_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (req.lane)
        );
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run, then look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_huff_tables -o tb_sim \
    > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }
grep -qx "Finished with no errors" sim.log && echo "Simulation PASSED" \
    || { echo "Simulation FAILED, see sim.log"; exit 1; }

// ==== testbench/huff_vectors.txt ====
0 0 00 2 0000
1 1 00 2 0000
0 0 01 3 0002
1 1 01 2 0001
0 0 02 3 0003
1 1 02 2 0002
0 0 03 3 0004
1 1 03 3 0006
0 0 04 3 0005
1 1 04 4 000e
0 0 05 3 0006
1 1 05 5 001e
0 0 06 4 000e
1 1 06 6 003e
0 0 07 5 001e
1 1 07 7 007e
0 0 08 6 003e
1 1 08 8 00fe
0 0 09 7 007e
1 1 09 9 01fe
0 0 0a 8 00fe
1 1 0a 10 03fe
0 0 0b 9 01fe
1 1 0b 11 07fe
0 0 0c 1 0000
1 1 0c 1 0000
0 2 01 2 0000
1 2 02 2 0001
0 2 03 3 0004
1 2 00 4 000a
0 0 ff 1 0000
1 1 10 1 0000
0 2 04 4 000b
1 2 11 4 000c
0 2 05 5 001a
1 2 12 5 001b
0 3 00 1 0000
1 2 31 6 003a
0 2 21 5 001c
1 3 5a 1 0000
0 2 41 6 003b
1 2 06 7 0078
0 2 13 7 0079
1 2 51 7 007a
0 2 0b 1 0000
1 2 22 8 00f9
0 2 07 8 00f8
1 2 32 9 01f7
0 2 14 9 01f6
1 2 fb 1 0000
0 2 a1 9 01fa
1 2 08 10 03f6
0 2 23 10 03f7
1 2 b1 10 03f9
0 3 82 1 0000
1 2 52 11 07f7
0 2 15 11 07f6
1 2 f0 11 07f9
0 2 d1 11 07f8
1 2 33 12 0ff5
0 2 24 12 0ff4
1 2 8b 1 0000
0 2 72 12 0ff7
1 2 82 15 7fc0
0 2 e0 1 0000
1 2 0a 16 ff83
0 2 09 16 ff82
1 2 7a 16 ffb5
0 2 16 16 ff84
1 2 f9 16 fffd
0 2 e1 16 ffeb
1 2 fa 16 fffe

// ==== testbench/tb_huff_tables.sv ====
`timescale 1ns/1ps
`include "huff_settings.svh"

module tb_huff_tables
    import huff_pkg::*;
();

    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 8;
    localparam int    LANES        = `HUFF_LANES;
    localparam int    SYM_W        = `HUFF_SYM_W;
    localparam int    MAX_VECTORS  = 256;
    localparam int    HOLD_CYCLES  = 16;
    localparam string VECTOR_FILE  = "testbench/huff_vectors.txt";

    logic                    clk;
    logic                    rst_n;
    logic [`HUFF_SYM_W-1:0]  symbol [`HUFF_LANES-1:0];
    logic                    re     [`HUFF_LANES-1:0];
    huff_table_t             sel    [`HUFF_LANES-1:0];
    logic [`HUFF_LEN_W-1:0]  len    [`HUFF_LANES-1:0];
    logic [`HUFF_CODE_W-1:0] code   [`HUFF_LANES-1:0];

    int                      vec_lane [MAX_VECTORS];
    huff_table_t             vec_sel  [MAX_VECTORS];
    logic [`HUFF_SYM_W-1:0]  vec_sym  [MAX_VECTORS];
    logic [`HUFF_LEN_W-1:0]  vec_len  [MAX_VECTORS];
    logic [`HUFF_CODE_W-1:0] vec_code [MAX_VECTORS];
    int                      vec_count;
    bit                      vectors_loaded;

    logic [`HUFF_LEN_W-1:0]  exp_len  [`HUFF_LANES-1:0];  // What each lane should show now.
    logic [`HUFF_CODE_W-1:0] exp_code [`HUFF_LANES-1:0];

    int error_count;
    int check_count;
    int test_count;

    huff_tables i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .symbol (symbol),
        .re     (re),
        .sel    (sel),
        .len    (len),
        .code   (code)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_len(input int lane, input logic [`HUFF_LEN_W-1:0] got,
                             input logic [`HUFF_LEN_W-1:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            $display("[ERROR] %0t: lane %0d %s, len is %0d, expected %0d",
                     $time, lane, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_code(input int lane, input logic [`HUFF_CODE_W-1:0] got,
                              input logic [`HUFF_CODE_W-1:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            $display("[ERROR] %0t: lane %0d %s, code is %h, expected %h",
                     $time, lane, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_lane(input int lane, input string what);
        check_len(lane, len[lane], exp_len[lane], what);
        check_code(lane, code[lane], exp_code[lane], what);
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        $display("Test %0d %-14s %0d errors", test_count, name, error_count - errs_before);
    endtask

    task automatic load_vectors();
        int fd;
        int n;
        int f_lane;
        int f_sel;
        int f_sym;
        int f_len;
        int f_code;
        vec_count = 0;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VECTOR_FILE);
            return;
        end
        n = $fscanf(fd, "%d %d %h %d %h\n", f_lane, f_sel, f_sym, f_len, f_code);
        while (n == 5 && vec_count < MAX_VECTORS) begin
            if (f_lane < 0 || f_lane >= LANES) begin
                $display("A vector names lane %0d, which does not exist", f_lane);
                error_count++;
            end else begin
                vec_lane[vec_count] = f_lane;
                vec_sel[vec_count]  = huff_table_t'(f_sel[1:0]);
                vec_sym[vec_count]  = f_sym[SYM_W-1:0];
                vec_len[vec_count]  = f_len[`HUFF_LEN_W-1:0];
                vec_code[vec_count] = f_code[`HUFF_CODE_W-1:0];
                vec_count++;
            end
            n = $fscanf(fd, "%d %d %h %d %h\n", f_lane, f_sel, f_sym, f_len, f_code);
        end
        $fclose(fd);
    endtask

    function automatic int next_of_lane(input int lane, input int start);
        for (int i = start; i < vec_count; i++) begin
            if (vec_lane[i] == lane) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Random inputs with re low; the lane must ignore them.
    task automatic drive_idle(input int lane);
        logic [31:0] rnd;
        rnd          = $urandom;
        symbol[lane] = rnd[SYM_W-1:0];
        sel[lane]    = huff_table_t'(rnd[SYM_W+1:SYM_W]);
        re[lane]     = 1'b0;
    endtask

    task automatic drive_request(input int lane, input int idx);
        symbol[lane] = vec_sym[idx];
        sel[lane]    = vec_sel[idx];
        re[lane]     = 1'b1;
    endtask

    task automatic run_reset_check();
        int errs_before;
        errs_before = error_count;
        for (int l = 0; l < LANES; l++) begin
            exp_len[l]  = '0;
            exp_code[l] = '0;
            check_lane(l, "after reset");
        end
        report_test("reset values", errs_before);
    endtask

    // One request at a time, random idle gaps in between.
    task automatic run_single_replay();
        int errs_before;
        int lane;
        int gap;
        errs_before = error_count;
        for (int i = 0; i < vec_count; i++) begin
            lane = vec_lane[i];
            for (int l = 0; l < LANES; l++) begin
                drive_idle(l);
            end
            drive_request(lane, i);
            @(negedge clk);
            exp_len[lane]  = vec_len[i];
            exp_code[lane] = vec_code[i];
            for (int l = 0; l < LANES; l++) begin
                check_lane(l, $sformatf("vector %0d", i));
            end
            gap = $urandom_range(0, 2);
            repeat (gap) begin
                for (int l = 0; l < LANES; l++) begin
                    drive_idle(l);
                end
                @(negedge clk);
                for (int l = 0; l < LANES; l++) begin
                    check_lane(l, $sformatf("hold after vector %0d", i));
                end
            end
        end
        report_test("single replay", errs_before);
    endtask

    task automatic run_long_hold();
        int errs_before;
        errs_before = error_count;
        repeat (HOLD_CYCLES) begin
            for (int l = 0; l < LANES; l++) begin
                drive_idle(l);
            end
            @(negedge clk);
            for (int l = 0; l < LANES; l++) begin
                check_lane(l, "long hold");
            end
        end
        report_test("long hold", errs_before);
    endtask

    // Every lane works through its own stream on the same cycles.
    task automatic run_dual_replay();
        int errs_before;
        int ptr [LANES];
        int cur [LANES];
        bit pending;
        errs_before = error_count;
        for (int l = 0; l < LANES; l++) begin
            ptr[l] = next_of_lane(l, 0);
        end
        pending = 1'b1;
        while (pending) begin
            pending = 1'b0;
            for (int l = 0; l < LANES; l++) begin
                cur[l] = ptr[l];
                if (ptr[l] >= 0) begin
                    drive_request(l, ptr[l]);
                    ptr[l]  = next_of_lane(l, ptr[l] + 1);
                    pending = 1'b1;
                end else begin
                    drive_idle(l);
                end
            end
            @(negedge clk);
            for (int l = 0; l < LANES; l++) begin
                if (cur[l] >= 0) begin
                    exp_len[l]  = vec_len[cur[l]];
                    exp_code[l] = vec_code[cur[l]];
                end
                check_lane(l, $sformatf("dual vector %0d", cur[l]));
            end
        end
        report_test("dual replay", errs_before);
    endtask

    initial begin
        void'($urandom(25));
        rst_n = 1'b0;
        for (int l = 0; l < LANES; l++) begin
            symbol[l] = '0;
            sel[l]    = DC_LUMA;
            re[l]     = 1'b0;
        end
        error_count    = 0;
        check_count    = 0;
        test_count     = 0;
        vectors_loaded = 1'b0;
        load_vectors();
        vectors_loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        if (vec_count == 0) begin
            $display("No vectors could be read from %s", VECTOR_FILE);
            $display("Finished with errors");
        end else begin
            @(negedge clk);
            run_reset_check();
            run_single_replay();
            run_long_hold();
            run_dual_replay();
            $display("Tests: %0d  Checks: %0d  Errors: %0d", test_count, check_count, error_count);
            if (error_count == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
        end
        $finish;
    end

    // Budget of four clocks per vector plus margin.
    initial begin
        wait (vectors_loaded);
        #((vec_count + 50) * 4 * CLK_PERIOD);
        $display("The simulation timed out before all tests completed");
        $display("Finished with errors");
        $finish;
    end

endmodule
